// File: core_ctrl_assert.sv
////////////////////////////////////////
// concurrent checks bound into core_ctrl_top
// sees the register struct and the selected pps output
////////////////////////////////////////

`timescale 1ns/1ps

module core_ctrl_assert
    import core_ctrl_pkg::*;
(
    input logic      i_radio_clk,
    input logic      i_bus_rst,
    input set_bus_t  i_set,
    input core_cfg_t i_cfg,
    input logic      i_pps
);

    // pps stays low once PPS_OFF has been held
    a_pps_off_low : assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        (i_cfg.pps_sel == PPS_OFF) && ($past(i_cfg.pps_sel, 1) == PPS_OFF)
            && ($past(i_cfg.pps_sel, 2) == PPS_OFF) |-> !i_pps)
        else $error("o_pps high while PPS_OFF selected");

    // misc register loads one cycle after its strobe
    a_misc_write : assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        (i_set.stb && i_set.addr == SR_CORE_MISC) |=> (i_cfg.misc_outs == $past(i_set.data)))
        else $error("misc_outs not updated after write");

    a_pps_reset_low : assert property (@(posedge i_radio_clk)
        $past(i_bus_rst) |-> !i_pps)
        else $error("o_pps high during reset");

endmodule

bind core_ctrl_top core_ctrl_assert u_assert (
    .i_radio_clk (i_radio_clk),
    .i_bus_rst   (i_bus_rst),
    .i_set       (i_set),
    .i_cfg       (cfg),
    .i_pps       (o_pps)
);

// File: core_ctrl_pkg.sv
////////////////////////////////////////
// shared definitions for the core control block
// setting addresses match the host driver map, only the low data bits are kept
////////////////////////////////////////

package core_ctrl_pkg;

    ////////////////////////////////////////
    // settings bus addresses
    ////////////////////////////////////////
    localparam logic [7:0] SR_CORE_MISC     = 8'd16;
    localparam logic [7:0] SR_CORE_READBACK = 8'd32;
    localparam logic [7:0] SR_CORE_GPSDO_ST = 8'd40;
    localparam logic [7:0] SR_CORE_PPS_SEL  = 8'd48;

    ////////////////////////////////////////
    // compatibility readback
    ////////////////////////////////////////
    localparam logic [31:0] COMPAT_SIGNATURE = 32'hACE0BA5E;
    localparam logic [15:0] COMPAT_MAJOR     = 16'h000B;
    localparam logic [15:0] COMPAT_MINOR     = 16'h0000;

    // single radio build
    localparam logic [7:0]  RADIO_STATUS     = 8'h01;

    // pps source choice, value of the PPS select register
    typedef enum logic [1:0] {
        PPS_GPSDO = 2'd0,
        PPS_EXT   = 2'd1,
        PPS_INT   = 2'd2,
        PPS_OFF   = 2'd3
    } pps_sel_e;

    // readback word choice
    typedef enum logic [1:0] {
        RB_COMPAT = 2'd0,
        // spi core is not present, slot reads zero
        RB_SPI    = 2'd1,
        RB_STATUS = 2'd2,
        RB_LOCK   = 2'd3
    } rb_sel_e;

    // settings bus write, one cycle strobe
    typedef struct packed {
        logic        stb;
        logic [7:0]  addr;
        logic [31:0] data;
    } set_bus_t;

    // registered core configuration
    typedef struct packed {
        logic [31:0] misc_outs;
        rb_sel_e     rb_sel;
        logic [7:0]  gpsdo_st;
        pps_sel_e    pps_sel;
    } core_cfg_t;

endpackage

// File: core_ctrl_tb.sv
////////////////////////////////////////
// testbench for core_ctrl_top with the internal pps period cut to 40 cycles
// a cycle model tracks the registers, the pps counter and all sync flops
////////////////////////////////////////

`timescale 1ns/1ps

module core_ctrl_tb
    import core_ctrl_pkg::*;
();

    localparam int PPS_PERIOD = 40;

    logic        radio_clk = 1'b0;
    logic        bus_rst;
    set_bus_t    set_bus;
    logic        pps_gpsdo;
    logic        pps_ext;
    logic [1:0]  lock;
    logic [31:0] rb_misc;
    logic [31:0] misc_outs;
    logic [63:0] rb_data;
    logic        pps;

    // input levels applied at the next rising edge
    logic        toggle_pps = 1'b0;
    logic        gpsdo_level = 1'b0;
    logic [1:0]  lock_level = 2'b00;
    logic [31:0] rb_misc_level = 32'h0;

    int n_checks = 0;
    int n_errors = 0;

    core_ctrl_top #(
        .PPS_PERIOD (PPS_PERIOD)
    ) i_dut (
        .i_radio_clk (radio_clk),
        .i_bus_rst   (bus_rst),
        .i_set       (set_bus),
        .i_pps_gpsdo (pps_gpsdo),
        .i_pps_ext   (pps_ext),
        .i_lock      (lock),
        .i_rb_misc   (rb_misc),
        .o_misc_outs (misc_outs),
        .o_rb_data   (rb_data),
        .o_pps       (pps)
    );

    always #10 radio_clk = ~radio_clk;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    logic [31:0] m_misc;
    rb_sel_e     m_rb_sel;
    logic [7:0]  m_gpsdo_st;
    pps_sel_e    m_pps_sel;
    int          m_cnt;
    logic [2:0]  m_pps_meta;
    logic [2:0]  m_pps_sync;
    logic [1:0]  m_lock_meta;
    logic [1:0]  m_lock_sync;

    always @(posedge radio_clk) begin
        if (bus_rst) begin
            m_misc      <= 32'h0;
            m_rb_sel    <= RB_COMPAT;
            m_pps_sel   <= PPS_GPSDO;
            m_cnt       <= 0;
            m_pps_meta  <= 3'b000;
            m_pps_sync  <= 3'b000;
            m_lock_meta <= 2'b00;
            m_lock_sync <= 2'b00;
        end else begin
            if (set_bus.stb && set_bus.addr == SR_CORE_MISC) begin
                m_misc <= set_bus.data;
            end
            if (set_bus.stb && set_bus.addr == SR_CORE_READBACK) begin
                m_rb_sel <= rb_sel_e'(set_bus.data[1:0]);
            end
            if (set_bus.stb && set_bus.addr == SR_CORE_PPS_SEL) begin
                m_pps_sel <= pps_sel_e'(set_bus.data[1:0]);
            end
            m_cnt       <= (m_cnt == PPS_PERIOD - 1) ? 0 : m_cnt + 1;
            m_pps_meta  <= {(m_cnt < PPS_PERIOD / 2), pps_ext, pps_gpsdo};
            m_pps_sync  <= m_pps_meta;
            m_lock_meta <= lock;
            m_lock_sync <= m_lock_meta;
        end
        // gpsdo status ignores reset
        if (set_bus.stb && set_bus.addr == SR_CORE_GPSDO_ST) begin
            m_gpsdo_st <= set_bus.data[7:0];
        end
    end

    function automatic logic [63:0] expected_rb();
        case (m_rb_sel)
            RB_COMPAT: return {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            RB_STATUS: return {16'h0, RADIO_STATUS, m_gpsdo_st, rb_misc};
            RB_LOCK:   return {62'h0, m_lock_sync};
            default:   return 64'h0;
        endcase
    endfunction

    function automatic logic expected_pps();
        case (m_pps_sel)
            PPS_GPSDO: return m_pps_sync[0];
            PPS_EXT:   return m_pps_sync[1];
            PPS_INT:   return m_pps_sync[2];
            default:   return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////
    // checks and stimulus tasks
    ////////////////////////////////////////

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        compare_value("misc_outs", {32'h0, misc_outs}, {32'h0, m_misc});
        compare_value("rb_data", rb_data, expected_rb());
        compare_value("pps", 64'(pps), 64'(expected_pps()));
    endtask

    // one clock with drive on the rising edge and check on the falling edge
    task automatic step_cycle(input logic do_write, input logic [7:0] addr,
                              input logic [31:0] data);
        logic [31:0] rnd;
        @(posedge radio_clk);
        set_bus.stb  <= do_write;
        set_bus.addr <= addr;
        set_bus.data <= data;
        lock         <= lock_level;
        rb_misc      <= rb_misc_level;
        if (toggle_pps) begin
            rnd = $urandom();
            pps_gpsdo <= rnd[0];
            pps_ext   <= rnd[1];
        end else begin
            pps_gpsdo <= gpsdo_level;
            pps_ext   <= 1'b0;
        end
        @(negedge radio_clk);
        check_outputs();
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step_cycle(1'b0, 8'h00, 32'h0);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        step_cycle(1'b1, addr, data);
        step_cycle(1'b0, 8'h00, 32'h0);
    endtask

    task automatic wait_for_pps(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (pps !== level && n < max_cycles) begin
            step_cycle(1'b0, 8'h00, 32'h0);
            n = n + 1;
        end
        if (pps !== level) begin
            n_errors = n_errors + 1;
            $display("timeout: o_pps did not reach %0b within %0d cycles",
                     level, max_cycles);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        logic [7:0]  addr;
        int          i;
        void'($urandom(32'hf2019e5c));
        bus_rst      <= 1'b1;
        set_bus      <= '0;
        pps_gpsdo    <= 1'b0;
        pps_ext      <= 1'b0;
        lock         <= 2'b00;
        rb_misc      <= 32'h0;
        repeat (8) @(posedge radio_clk);
        bus_rst <= 1'b0;
        @(negedge radio_clk);

        // reset values with gpsdo as the default pps source
        compare_value("reset misc_outs", {32'h0, misc_outs}, 64'h0);
        compare_value("reset compat", rb_data, {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR});
        gpsdo_level = 1'b1;
        wait_for_pps(1'b1, 10);
        gpsdo_level = 1'b0;
        wait_for_pps(1'b0, 10);
        write_reg(SR_CORE_GPSDO_ST, $urandom());

        // random writes to mapped and unmapped addresses
        for (i = 0; i < 200; i = i + 1) begin
            rnd = $urandom();
            case (rnd[2:0])
                3'd0:    addr = SR_CORE_MISC;
                3'd1:    addr = SR_CORE_READBACK;
                3'd2:    addr = SR_CORE_GPSDO_ST;
                3'd3:    addr = SR_CORE_PPS_SEL;
                default: addr = rnd[15:8];
            endcase
            write_reg(addr, $urandom());
        end

        // every readback select
        write_reg(SR_CORE_GPSDO_ST, $urandom());
        for (i = 0; i < 4; i = i + 1) begin
            rb_misc_level = $urandom();
            write_reg(SR_CORE_READBACK, 32'(i));
            run_cycles(3);
        end
        for (i = 0; i < 8; i = i + 1) begin
            rnd = $urandom();
            lock_level = rnd[1:0];
            run_cycles(3);
        end

        // external sources toggling at random
        toggle_pps = 1'b1;
        write_reg(SR_CORE_PPS_SEL, {30'h0, PPS_GPSDO});
        run_cycles(30);
        write_reg(SR_CORE_PPS_SEL, {30'h0, PPS_EXT});
        run_cycles(30);
        write_reg(SR_CORE_PPS_SEL, {30'h0, PPS_OFF});
        run_cycles(30);
        toggle_pps = 1'b0;

        // internal generator over several periods
        write_reg(SR_CORE_PPS_SEL, {30'h0, PPS_INT});
        wait_for_pps(1'b1, 2 * PPS_PERIOD + 4);
        wait_for_pps(1'b0, PPS_PERIOD + 4);
        run_cycles(4 * PPS_PERIOD);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: core_ctrl_top.f
core_ctrl_pkg.sv
core_settings_regs.sv
pps_source_sel.sv
status_readback.sv
core_ctrl_top.sv
core_ctrl_assert.sv
core_ctrl_tb.sv

// File: core_ctrl_top.sv
////////////////////////////////////////
// board core control, single radio_clk domain
// settings strobe is a plain one cycle pulse, no handshake
////////////////////////////////////////

`timescale 1ns/1ps

module core_ctrl_top
    import core_ctrl_pkg::*;
#(
    parameter int PPS_PERIOD = 100000000
) (
    input  logic        i_radio_clk,
    input  logic        i_bus_rst,
    // settings bus
    input  set_bus_t    i_set,
    // pps inputs
    input  logic        i_pps_gpsdo,
    input  logic        i_pps_ext,
    // status inputs
    input  logic [1:0]  i_lock,
    input  logic [31:0] i_rb_misc,
    // outputs
    output logic [31:0] o_misc_outs,
    output logic [63:0] o_rb_data,
    output logic        o_pps
);

    core_cfg_t cfg;

    ////////////////////////////////////////
    // setting registers
    ////////////////////////////////////////

    core_settings_regs u_settings_regs (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_set       (i_set),
        .o_cfg       (cfg)
    );

    assign o_misc_outs = cfg.misc_outs;

    ////////////////////////////////////////
    // pps and readback
    ////////////////////////////////////////

    pps_source_sel #(
        .PPS_PERIOD (PPS_PERIOD)
    ) u_pps_source_sel (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_pps_gpsdo (i_pps_gpsdo),
        .i_pps_ext   (i_pps_ext),
        .i_pps_sel   (cfg.pps_sel),
        .o_pps       (o_pps)
    );

    status_readback u_status_readback (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_lock      (i_lock),
        .i_rb_misc   (i_rb_misc),
        .i_rb_sel    (cfg.rb_sel),
        .i_gpsdo_st  (cfg.gpsdo_st),
        .o_rb_data   (o_rb_data)
    );

endmodule

// File: core_settings_regs.sv
////////////////////////////////////////
// core setting registers, written one cycle after the strobe
// gpsdo status has no reset and reads X until first written
////////////////////////////////////////

`timescale 1ns/1ps

module core_settings_regs
    import core_ctrl_pkg::*;
(
    input  logic      i_radio_clk,
    input  logic      i_bus_rst,
    input  set_bus_t  i_set,
    output core_cfg_t o_cfg
);

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    logic wr_misc;
    logic wr_rb_sel;
    logic wr_gpsdo_st;
    logic wr_pps_sel;

    // unmapped addresses match nothing and are dropped
    assign wr_misc     = i_set.stb && (i_set.addr == SR_CORE_MISC);
    assign wr_rb_sel   = i_set.stb && (i_set.addr == SR_CORE_READBACK);
    assign wr_gpsdo_st = i_set.stb && (i_set.addr == SR_CORE_GPSDO_ST);
    assign wr_pps_sel  = i_set.stb && (i_set.addr == SR_CORE_PPS_SEL);

    ////////////////////////////////////////
    // register storage
    ////////////////////////////////////////

    logic [31:0] misc_outs_q;
    rb_sel_e     rb_sel_q;
    logic [7:0]  gpsdo_st_q;
    pps_sel_e    pps_sel_q;

    // control fields
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            misc_outs_q <= 32'h0;
            rb_sel_q    <= RB_COMPAT;
            pps_sel_q   <= PPS_GPSDO;
        end else begin
            if (wr_misc) begin
                misc_outs_q <= i_set.data;
            end
            if (wr_rb_sel) begin
                rb_sel_q <= rb_sel_e'(i_set.data[1:0]);
            end
            if (wr_pps_sel) begin
                pps_sel_q <= pps_sel_e'(i_set.data[1:0]);
            end
        end
    end

    // gpsdo status survives a core reset
    always_ff @(posedge i_radio_clk) begin
        if (wr_gpsdo_st) begin
            gpsdo_st_q <= i_set.data[7:0];
        end
    end

    ////////////////////////////////////////
    // configuration out
    ////////////////////////////////////////

    always_comb begin
        o_cfg           = '0;
        o_cfg.misc_outs = misc_outs_q;
        o_cfg.rb_sel    = rb_sel_q;
        o_cfg.gpsdo_st  = gpsdo_st_q;
        o_cfg.pps_sel   = pps_sel_q;
    end

endmodule

// File: pps_source_sel.sv
////////////////////////////////////////
// pps source mux, every source sees two sync flops
// PPS_PERIOD is in radio_clk cycles, output high for the first half
////////////////////////////////////////

`timescale 1ns/1ps

module pps_source_sel
    import core_ctrl_pkg::*;
#(
    parameter int PPS_PERIOD = 100000000
) (
    input  logic     i_radio_clk,
    input  logic     i_bus_rst,
    input  logic     i_pps_gpsdo,
    input  logic     i_pps_ext,
    input  pps_sel_e i_pps_sel,
    output logic     o_pps
);

    localparam int CNT_W = (PPS_PERIOD > 1) ? $clog2(PPS_PERIOD) : 1;

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PPS_PERIOD - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(PPS_PERIOD / 2);

    ////////////////////////////////////////
    // internal pps generator
    ////////////////////////////////////////

    logic [CNT_W-1:0] pps_cnt;
    logic             pps_int;

    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            pps_cnt <= '0;
        end else if (pps_cnt == CNT_LAST) begin
            pps_cnt <= '0;
        end else begin
            pps_cnt <= pps_cnt + 1'b1;
        end
    end

    // high during the first half of each period
    assign pps_int = (pps_cnt < CNT_HALF);

    ////////////////////////////////////////
    // source synchronizers
    ////////////////////////////////////////

    // bit 0 gpsdo, bit 1 external, bit 2 internal
    logic [2:0] pps_raw;
    logic [2:0] pps_meta;
    logic [2:0] pps_sync;

    assign pps_raw = {pps_int, i_pps_ext, i_pps_gpsdo};

    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            pps_meta <= 3'b000;
            pps_sync <= 3'b000;
        end else begin
            pps_meta <= pps_raw;
            pps_sync <= pps_meta;
        end
    end

    ////////////////////////////////////////
    // source select
    ////////////////////////////////////////

    always_comb begin
        case (i_pps_sel)
            PPS_GPSDO: o_pps = pps_sync[0];
            PPS_EXT:   o_pps = pps_sync[1];
            PPS_INT:   o_pps = pps_sync[2];
            // no pps to the radio
            PPS_OFF:   o_pps = 1'b0;
            default:   o_pps = 1'b0;
        endcase
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module core_ctrl_tb \
    -f core_ctrl_top.f \
    --Mdir obj_dir \
    -o sim_core_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_core_ctrl > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi

if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0

// File: status_readback.sv
////////////////////////////////////////
// 64 bit readback word, combinational on the select
// lock bits arrive two cycles late through their sync flops
////////////////////////////////////////

`timescale 1ns/1ps

module status_readback
    import core_ctrl_pkg::*;
(
    input  logic        i_radio_clk,
    input  logic        i_bus_rst,
    input  logic [1:0]  i_lock,
    input  logic [31:0] i_rb_misc,
    input  rb_sel_e     i_rb_sel,
    input  logic [7:0]  i_gpsdo_st,
    output logic [63:0] o_rb_data
);

    ////////////////////////////////////////
    // front end lock sync
    ////////////////////////////////////////

    logic [1:0] lock_meta;
    logic [1:0] lock_sync;

    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            lock_meta <= 2'b00;
            lock_sync <= 2'b00;
        end else begin
            lock_meta <= i_lock;
            lock_sync <= lock_meta;
        end
    end

    ////////////////////////////////////////
    // readback mux
    ////////////////////////////////////////

    always_comb begin
        case (i_rb_sel)
            RB_COMPAT: begin
                o_rb_data = {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            end
            RB_SPI: begin
                // spi slot left empty
                o_rb_data = 64'h0;
            end
            RB_STATUS: begin
                o_rb_data = {16'h0, RADIO_STATUS, i_gpsdo_st, i_rb_misc};
            end
            RB_LOCK: begin
                o_rb_data = {62'h0, lock_sync};
            end
            default: begin
                o_rb_data = 64'h0;
            end
        endcase
    end

endmodule
